// File: Makefile
TOP := ulpi_axis_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "CHECKS FAILED" sim.log

lint:
	verilator --lint-only -Wall --top-module ulpi_axis design/ulpi_pkg.sv \
	  design/ulpi_reset_sync.sv design/ulpi_line_state.sv design/ulpi_decoder.sv \
	  design/ulpi_encoder.sv design/ulpi_axis.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: bench/ulpi_axis_tb.sv
`timescale 1ns/1ps
module ulpi_axis_tb;

  typedef struct packed {
    logic [2:0]  kind;   // 0 rx cmd, 1 rx packet, 2 tx packet, 3 reg write, 4 write with packet
    logic [2:0]  len;    // packet bytes, pid included
    logic [5:0]  addr;   // phy register
    logic [7:0]  wdata;  // register value
    logic [31:0] bytes;  // first byte in the low lane
    logic [7:0]  exp;    // rx cmd {rx error, rx active, vbus valid, line state}, else first bus byte
  } entry_t;

  localparam int N_ENTRIES = 10;
  localparam int LIMIT     = 200;  // cycles allowed per wait

  logic       clock = 1'b0;
  logic       areset_n, reset_no;
  logic       ulpi_dir_i, ulpi_nxt_i, ulpi_stp_o, ulpi_data_oe_o;
  logic [7:0] ulpi_data_i, ulpi_data_o;
  logic [1:0] line_state_o;
  logic       vbus_valid_o, rx_active_o, rx_error_o;
  logic       s_axis_tvalid_i, s_axis_tlast_i, s_axis_tready_o;
  logic [7:0] s_axis_tdata_i, m_axis_tdata_o, phy_data_i;
  logic       m_axis_tvalid_o, m_axis_tlast_o;
  logic       phy_write_i, phy_busy_o, phy_done_o;
  logic [5:0] phy_addr_i;

  entry_t      table_q [N_ENTRIES];
  logic [8:0]  rx_q [$];             // {tlast, tdata} off m_axis
  logic [7:0]  bus_q [$];            // bytes the phy took
  logic [31:0] lfsr_q = 32'd82661;
  logic [31:0] tx_bytes;             // stream source
  int          tx_len, tx_idx, done_cnt, checks, errors;
  bit          timed_out;

  ulpi_axis #(.VBUS_VALID_MIN(2'd3)) dut0 (.*);

  always #10 clock = ~clock;  // 20 ns phy clock

  // receive stream and done pulses, bus ownership
  always @(negedge clock) begin
    if (m_axis_tvalid_o) rx_q.push_back({m_axis_tlast_o, m_axis_tdata_o});
    if (phy_done_o) done_cnt++;
    assert (!(ulpi_data_oe_o && ulpi_dir_i)) else begin
      $display("link drove the data bus while the phy held dir high at %0t", $time);
      errors++;
    end
  end

  // right shifting galois lfsr
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("gave up waiting for %s at %0t", what, $time);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic run_rx_cmd(input logic [7:0] cmd, input logic [7:0] exp);
    @(posedge clock);
    ulpi_dir_i  <= 1'b1;
    ulpi_nxt_i  <= 1'b0;
    ulpi_data_i <= 8'h00;  // turnaround, ignored
    @(posedge clock);
    ulpi_data_i <= cmd;
    @(posedge clock);
    ulpi_dir_i  <= 1'b0;   // fields registered on this edge
    @(negedge clock);
    check_val("line_state_o", line_state_o, exp[1:0]);
    check_val("vbus_valid_o", vbus_valid_o, exp[2]);
    check_val("rx_active_o", rx_active_o, exp[3]);
    check_val("rx_error_o", rx_error_o, exp[4]);
  endtask

  task automatic run_rx_packet(input int len, input logic [31:0] bytes);
    rx_q.delete();
    @(posedge clock);
    ulpi_dir_i  <= 1'b1;
    ulpi_nxt_i  <= 1'b0;
    ulpi_data_i <= 8'h00;
    @(posedge clock);
    ulpi_data_i <= 8'h10;  // rx cmd, rxactive set
    for (int i = 0; i < len; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      if (lfsr_q[0]) begin  // rx cmd gap between bytes
        @(posedge clock);
        ulpi_nxt_i  <= 1'b0;
        ulpi_data_i <= 8'h10;
      end
      @(posedge clock);
      ulpi_nxt_i  <= 1'b1;
      ulpi_data_i <= bytes[8*i +: 8];
    end
    @(posedge clock);
    ulpi_dir_i <= 1'b0;  // dir fall closes the packet
    ulpi_nxt_i <= 1'b0;
    for (int t = 0; t < LIMIT && rx_q.size() < len; t++) @(negedge clock);
    if (rx_q.size() < len) note_timeout("received bytes");
    foreach (rx_q[i]) begin
      check_val("m_axis_tdata_o", rx_q[i][7:0], bytes[8*i +: 8]);
      check_val("m_axis_tlast_o", rx_q[i][8], i == len - 1);
    end
  endtask

  // call right after a rising edge
  task automatic offer_packet(input int len, input logic [31:0] bytes);
    tx_len   = len;
    tx_idx   = 0;
    tx_bytes = bytes;
    s_axis_tvalid_i <= 1'b1;
    s_axis_tdata_i  <= bytes[7:0];  // pid first
    s_axis_tlast_i  <= (len == 1);
  endtask

  // phy side while the link drives, up to and one past stp
  task automatic serve_link(input logic busy_exp);
    logic took, acc_q, stopped;
    bus_q.delete();
    took    = 1'b0;
    acc_q   = 1'b0;
    stopped = 1'b0;
    for (int t = 0; t < LIMIT && !stopped; t++) begin
      @(posedge clock);
      lfsr_q = lfsr_step(lfsr_q);
      ulpi_nxt_i  <= lfsr_q[0];  // random stall
      phy_write_i <= 1'b0;       // strobe is one cycle
      if (took) begin
        tx_idx++;
        s_axis_tvalid_i <= (tx_idx < tx_len);
        s_axis_tlast_i  <= (tx_idx == tx_len - 1);
        if (tx_idx < tx_len) s_axis_tdata_i <= tx_bytes[8*tx_idx +: 8];
      end
      @(negedge clock);
      took = s_axis_tready_o;
      if (busy_exp) check_val("phy_busy_o", phy_busy_o, 1'b1);
      if (ulpi_stp_o) begin
        stopped = 1'b1;
        check_val("ulpi_data_o at stp", ulpi_data_o, 8'h00);
        check_val("accept right before stp", acc_q, 1'b1);
      end else if (ulpi_data_oe_o && ulpi_nxt_i) begin
        bus_q.push_back(ulpi_data_o);
      end
      acc_q = ulpi_data_oe_o && ulpi_nxt_i;
    end
    if (!stopped) note_timeout("stp");
    @(posedge clock);
    ulpi_nxt_i <= 1'b0;
    @(negedge clock);
    check_val("ulpi_stp_o after stp", ulpi_stp_o, 1'b0);
  endtask

  task automatic check_bus(input logic [7:0] first, input int len, input logic [31:0] bytes);
    check_val("bus byte count", bus_q.size(), len);
    foreach (bus_q[i]) check_val("ulpi_data_o", bus_q[i], i == 0 ? first : bytes[8*i +: 8]);
  endtask

  task automatic run_link(input entry_t en);
    int done0;
    done0 = done_cnt;
    @(posedge clock);
    if (en.kind != 3'd2) begin
      phy_write_i <= 1'b1;
      phy_addr_i  <= en.addr;
      phy_data_i  <= en.wdata;
    end
    if (en.kind != 3'd3) offer_packet(en.len, en.bytes);  // waits behind any write
    if (en.kind != 3'd2) begin
      serve_link(1'b1);
      check_bus(en.exp, 2, {16'h0000, en.wdata, 8'h00});
      check_val("phy_done_o", phy_done_o, 1'b1);
      check_val("phy_busy_o", phy_busy_o, 1'b0);
      @(negedge clock);
      check_val("phy_done_o pulse count", done_cnt - done0, 8'd1);
    end
    if (en.kind != 3'd3) begin
      serve_link(1'b0);
      check_bus(en.kind == 3'd2 ? en.exp : {2'b01, 2'b00, en.bytes[3:0]}, en.len, en.bytes);
    end
  endtask

  initial begin
    int n;
    areset_n        = 1'b0;
    ulpi_dir_i      = 1'b0;
    ulpi_nxt_i      = 1'b0;
    ulpi_data_i     = 8'h00;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    s_axis_tdata_i  = 8'h00;
    phy_write_i     = 1'b0;
    phy_addr_i      = 6'h00;
    phy_data_i      = 8'h00;
    // kind, len, addr, wdata, bytes, exp
    table_q[0] = '{3'd0, 3'd0, 6'h00, 8'h00, 32'h0000_000D, 8'h05};
    table_q[1] = '{3'd0, 3'd0, 6'h00, 8'h00, 32'h0000_0016, 8'h0A};
    table_q[2] = '{3'd1, 3'd4, 6'h00, 8'h00, 32'hA55A_17C3, 8'h00};
    table_q[3] = '{3'd2, 3'd4, 6'h00, 8'h00, 32'h9E02_00C3, 8'h43};
    table_q[4] = '{3'd3, 3'd0, 6'h0A, 8'h45, 32'h0000_0000, 8'h8A};
    table_q[5] = '{3'd1, 3'd1, 6'h00, 8'h00, 32'h0000_00D2, 8'h00};
    table_q[6] = '{3'd0, 3'd0, 6'h00, 8'h00, 32'h0000_000E, 8'h06};
    table_q[7] = '{3'd2, 3'd1, 6'h00, 8'h00, 32'h0000_00D2, 8'h42};
    table_q[8] = '{3'd4, 3'd3, 6'h16, 8'h55, 32'h00F0_0F4B, 8'h96};
    table_q[9] = '{3'd0, 3'd0, 6'h00, 8'h00, 32'h0000_003B, 8'h1B};
    for (int i = 0; i < 10; i++) begin
      @(negedge clock);
      check_val("stp oe tready tvalid busy done", {ulpi_stp_o, ulpi_data_oe_o, s_axis_tready_o,
                m_axis_tvalid_o, phy_busy_o, phy_done_o}, 8'h00);
    end
    @(posedge clock);
    areset_n <= 1'b1;
    n = 0;
    @(negedge clock);
    while (!reset_no && n < 10) begin
      check_val("stp oe tready tvalid busy done", {ulpi_stp_o, ulpi_data_oe_o, s_axis_tready_o,
                m_axis_tvalid_o, phy_busy_o, phy_done_o}, 8'h00);
      @(negedge clock);
      n++;
    end
    if (!reset_no) note_timeout("reset release");
    check_val("reset_no rise cycles", n, 8'd2);
    for (int e = 0; e < N_ENTRIES && !timed_out; e++) begin
      case (table_q[e].kind)
        3'd0:    run_rx_cmd(table_q[e].bytes[7:0], table_q[e].exp);
        3'd1:    run_rx_packet(table_q[e].len, table_q[e].bytes);
        default: run_link(table_q[e]);
      endcase
    end
    repeat (4) @(negedge clock);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: design/ulpi_axis.sv
`timescale 1ns/1ps
module ulpi_axis #(
  parameter ulpi_pkg::vbus_state_t VBUS_VALID_MIN = 2'd3
) (
  input  logic                     clock,  // from the phy
  input  logic                     areset_n,
  output logic                     reset_no,

  // ulpi, data bus split for an outside pad
  input  logic                     ulpi_dir_i,
  input  logic                     ulpi_nxt_i,
  input  ulpi_pkg::ulpi_byte_t     ulpi_data_i,
  output logic                     ulpi_stp_o,
  output ulpi_pkg::ulpi_byte_t     ulpi_data_o,
  output logic                     ulpi_data_oe_o,

  // decoded rx cmd state
  output ulpi_pkg::line_state_t    line_state_o,
  output logic                     vbus_valid_o,
  output logic                     rx_active_o,
  output logic                     rx_error_o,

  // host bound packets
  input  logic                     s_axis_tvalid_i,
  input  logic                     s_axis_tlast_i,
  input  ulpi_pkg::ulpi_byte_t     s_axis_tdata_i,
  output logic                     s_axis_tready_o,

  // received packets, no stall possible
  output logic                     m_axis_tvalid_o,
  output logic                     m_axis_tlast_o,
  output ulpi_pkg::ulpi_byte_t     m_axis_tdata_o,

  // phy register writes
  input  logic                     phy_write_i,
  input  ulpi_pkg::ulpi_reg_addr_t phy_addr_i,
  input  ulpi_pkg::ulpi_byte_t     phy_data_i,
  output logic                     phy_busy_o,
  output logic                     phy_done_o
);

  logic                 rx_byte_valid_w;
  ulpi_pkg::ulpi_byte_t rx_byte_w;
  logic                 rx_end_w;
  logic                 bus_turn_w;

  ulpi_reset_sync u_reset_sync (
    .clock    (clock),
    .areset_n (areset_n),
    .reset_no (reset_no)
  );

  ulpi_line_state #(
    .VBUS_VALID_MIN (VBUS_VALID_MIN)
  ) u_line_state (
    .clock           (clock),
    .areset_n        (reset_no),  // synced release
    .ulpi_dir_i      (ulpi_dir_i),
    .ulpi_nxt_i      (ulpi_nxt_i),
    .ulpi_data_i     (ulpi_data_i),
    .line_state_o    (line_state_o),
    .vbus_valid_o    (vbus_valid_o),
    .rx_active_o     (rx_active_o),
    .rx_error_o      (rx_error_o),
    .rx_byte_valid_o (rx_byte_valid_w),
    .rx_byte_o       (rx_byte_w),
    .rx_end_o        (rx_end_w),
    .bus_turn_o      (bus_turn_w)
  );

  ulpi_decoder u_decoder (
    .clock           (clock),
    .areset_n        (reset_no),
    .rx_byte_valid_i (rx_byte_valid_w),
    .rx_byte_i       (rx_byte_w),
    .rx_end_i        (rx_end_w),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tdata_o  (m_axis_tdata_o)
  );

  ulpi_encoder u_encoder (
    .clock           (clock),
    .areset_n        (reset_no),
    .ulpi_dir_i      (ulpi_dir_i),
    .ulpi_nxt_i      (ulpi_nxt_i),
    .bus_turn_i      (bus_turn_w),  // shared turnaround view
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .phy_write_i     (phy_write_i),
    .phy_addr_i      (phy_addr_i),
    .phy_data_i      (phy_data_i),
    .s_axis_tready_o (s_axis_tready_o),
    .ulpi_data_o     (ulpi_data_o),
    .ulpi_data_oe_o  (ulpi_data_oe_o),
    .ulpi_stp_o      (ulpi_stp_o),
    .phy_busy_o      (phy_busy_o),
    .phy_done_o      (phy_done_o)
  );

endmodule

// File: design/ulpi_decoder.sv
`timescale 1ns/1ps
module ulpi_decoder (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 rx_byte_valid_i,
  input  ulpi_pkg::ulpi_byte_t rx_byte_i,
  input  logic                 rx_end_i,
  output logic                 m_axis_tvalid_o,
  output logic                 m_axis_tlast_o,
  output ulpi_pkg::ulpi_byte_t m_axis_tdata_o
);

  ulpi_pkg::ulpi_byte_t hold_q;        // byte waiting to learn if it is last
  logic                 hold_valid_q;

  // holding slot
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      hold_valid_q <= 1'b0;
    end else if (rx_byte_valid_i) begin
      hold_valid_q <= 1'b1;
    end else if (rx_end_i) begin
      hold_valid_q <= 1'b0;  // flushed as last
    end
  end

  always_ff @(posedge clock) begin
    if (rx_byte_valid_i) begin
      hold_q <= rx_byte_i;
    end
  end

  // stream side control, one pulse per byte
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      m_axis_tvalid_o <= 1'b0;
      m_axis_tlast_o  <= 1'b0;
    end else begin
      // new byte pushes the held one out, end flushes it with last
      m_axis_tvalid_o <= hold_valid_q & (rx_byte_valid_i | rx_end_i);
      m_axis_tlast_o  <= hold_valid_q & rx_end_i & ~rx_byte_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (hold_valid_q && (rx_byte_valid_i || rx_end_i)) begin
      m_axis_tdata_o <= hold_q;
    end
  end

  // last only comes with a valid byte, and only after a packet end
  a_last_with_valid : assert property (
    @(posedge clock) disable iff (!areset_n)
    m_axis_tlast_o |-> m_axis_tvalid_o && $past(rx_end_i)
  );

endmodule

// File: design/ulpi_encoder.sv
`timescale 1ns/1ps
module ulpi_encoder (
  input  logic                     clock,
  input  logic                     areset_n,
  input  logic                     ulpi_dir_i,
  input  logic                     ulpi_nxt_i,
  input  logic                     bus_turn_i,
  input  logic                     s_axis_tvalid_i,
  input  logic                     s_axis_tlast_i,
  input  ulpi_pkg::ulpi_byte_t     s_axis_tdata_i,
  input  logic                     phy_write_i,
  input  ulpi_pkg::ulpi_reg_addr_t phy_addr_i,
  input  ulpi_pkg::ulpi_byte_t     phy_data_i,
  output logic                     s_axis_tready_o,
  output ulpi_pkg::ulpi_byte_t     ulpi_data_o,
  output logic                     ulpi_data_oe_o,
  output logic                     ulpi_stp_o,
  output logic                     phy_busy_o,
  output logic                     phy_done_o
);

  ulpi_pkg::enc_state_t     state_q;
  ulpi_pkg::ulpi_reg_addr_t addr_q;     // captured write address
  ulpi_pkg::ulpi_byte_t     data_q;     // captured write value
  logic                     bus_free_w; // link may drive this cycle
  logic                     adv_w;      // phy took the byte
  logic                     accept_w;   // new write strobe taken
  logic                     in_tx_w;

  assign bus_free_w = ~ulpi_dir_i & ~bus_turn_i;
  assign adv_w      = ulpi_nxt_i & bus_free_w;
  assign accept_w   = phy_write_i & ~phy_busy_o;  // strobes ignored while busy
  assign in_tx_w    = (state_q == ulpi_pkg::tx_pid) || (state_q == ulpi_pkg::tx_data);

  always_ff @(posedge clock) begin
    if (accept_w) begin
      addr_q <= phy_addr_i;
      data_q <= phy_data_i;
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q    <= ulpi_pkg::idle;
      phy_busy_o <= 1'b0;
      phy_done_o <= 1'b0;
    end else begin
      phy_done_o <= 1'b0;
      if (accept_w) phy_busy_o <= 1'b1;  // also marks a pending write
      case (state_q)
        ulpi_pkg::idle: begin
          if (bus_free_w) begin
            if (phy_busy_o || accept_w) state_q <= ulpi_pkg::reg_cmd;  // writes first
            else if (s_axis_tvalid_i) state_q <= ulpi_pkg::tx_pid;
          end
        end
        ulpi_pkg::tx_pid, ulpi_pkg::tx_data: begin
          if (adv_w) begin
            state_q <= s_axis_tlast_i ? ulpi_pkg::tx_stop : ulpi_pkg::tx_data;
          end
        end
        ulpi_pkg::reg_cmd:  if (adv_w) state_q <= ulpi_pkg::reg_data;
        ulpi_pkg::reg_data: if (adv_w) state_q <= ulpi_pkg::reg_stop;
        ulpi_pkg::reg_stop: begin
          state_q    <= ulpi_pkg::idle;
          phy_busy_o <= 1'b0;
          phy_done_o <= 1'b1;  // the cycle after stp
        end
        default: state_q <= ulpi_pkg::idle;  // tx_stop, one cycle
      endcase
    end
  end

  // byte on the bus, decoded from state
  always_comb begin
    case (state_q)
      ulpi_pkg::tx_pid:   ulpi_data_o = {ulpi_pkg::TXCMD_TRANSMIT, 2'b00, s_axis_tdata_i[3:0]};
      ulpi_pkg::tx_data:  ulpi_data_o = s_axis_tdata_i;
      ulpi_pkg::reg_cmd:  ulpi_data_o = {ulpi_pkg::TXCMD_REG_WRITE, addr_q};
      ulpi_pkg::reg_data: ulpi_data_o = data_q;
      default:            ulpi_data_o = '0;  // idle and stp cycles
    endcase
  end

  assign ulpi_data_oe_o  = (state_q != ulpi_pkg::idle) & bus_free_w;  // back off if phy turns
  assign ulpi_stp_o      = (state_q == ulpi_pkg::tx_stop) || (state_q == ulpi_pkg::reg_stop);
  assign s_axis_tready_o = in_tx_w & adv_w;  // pid is consumed with its tx cmd

  // never drive in the turnaround after the phy released the bus
  a_oe_off_bus : assert property (
    @(posedge clock) disable iff (!areset_n)
    ulpi_data_oe_o |-> !ulpi_dir_i && !$past(ulpi_dir_i)
  );

  a_stp_one_cycle : assert property (
    @(posedge clock) disable iff (!areset_n)
    ulpi_stp_o |=> !ulpi_stp_o
  );

endmodule

// File: design/ulpi_line_state.sv
`timescale 1ns/1ps
module ulpi_line_state #(
  parameter ulpi_pkg::vbus_state_t VBUS_VALID_MIN = 2'd3
) (
  input  logic                    clock,
  input  logic                    areset_n,
  input  logic                    ulpi_dir_i,
  input  logic                    ulpi_nxt_i,
  input  ulpi_pkg::ulpi_byte_t    ulpi_data_i,
  output ulpi_pkg::line_state_t   line_state_o,
  output logic                    vbus_valid_o,
  output logic                    rx_active_o,
  output logic                    rx_error_o,
  output logic                    rx_byte_valid_o,
  output ulpi_pkg::ulpi_byte_t    rx_byte_o,
  output logic                    rx_end_o,
  output logic                    bus_turn_o
);

  logic                  dir_q;      // dir one clock back
  logic                  rx_cmd_w;   // this cycle carries an rx cmd
  logic                  dir_fall_w;
  ulpi_pkg::rx_event_t   event_w;
  ulpi_pkg::vbus_state_t vbus_w;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      dir_q <= 1'b0;
    end else begin
      dir_q <= ulpi_dir_i;
    end
  end

  // any dir edge costs one dead cycle
  assign bus_turn_o = ulpi_dir_i ^ dir_q;
  assign dir_fall_w = dir_q & ~ulpi_dir_i;

  assign rx_cmd_w = ulpi_dir_i & ~ulpi_nxt_i & ~bus_turn_o;
  assign event_w  = ulpi_data_i[5:4];
  assign vbus_w   = ulpi_data_i[3:2];

  // rx cmd fields, registered
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      line_state_o <= '0;
      vbus_valid_o <= 1'b0;
      rx_active_o  <= 1'b0;
      rx_error_o   <= 1'b0;
    end else if (rx_cmd_w) begin
      line_state_o <= ulpi_data_i[1:0];
      vbus_valid_o <= (vbus_w >= VBUS_VALID_MIN);  // threshold set from the top
      rx_active_o  <= event_w[0];
      rx_error_o   <= (event_w == ulpi_pkg::RX_EVENT_ERROR);
    end else if (dir_fall_w) begin
      rx_active_o <= 1'b0;  // phy dropped the bus, packet is over
      rx_error_o  <= 1'b0;
    end
  end

  // dir and nxt both high is packet data
  assign rx_byte_valid_o = ulpi_dir_i & ulpi_nxt_i & ~bus_turn_o;
  assign rx_byte_o       = ulpi_data_i;

  // packet closes on dir fall or on rx cmd with rxactive low, only once
  assign rx_end_o = rx_active_o & (dir_fall_w | (rx_cmd_w & ~event_w[0]));

  // no data byte may slip through in the cycle right after dir moved
  a_no_byte_in_turn : assert property (
    @(posedge clock) disable iff (!areset_n)
    (ulpi_dir_i != $past(ulpi_dir_i)) |-> !rx_byte_valid_o
  );

endmodule

// File: design/ulpi_pkg.sv
package ulpi_pkg;

  // bus and stream byte
  typedef logic [7:0] ulpi_byte_t;

  // phy register address, low six bits of a reg write tx cmd
  typedef logic [5:0] ulpi_reg_addr_t;

  typedef logic [1:0] line_state_t;  // bit 0 is d+, bit 1 is d-
  typedef logic [1:0] vbus_state_t;  // encoded vbus level from rx cmd
  typedef logic [1:0] rx_event_t;    // {rx error, rx active} field

  // tx cmd prefixes, top two bits of the command byte
  localparam logic [1:0] TXCMD_TRANSMIT  = 2'b01;  // low nibble carries the pid
  localparam logic [1:0] TXCMD_REG_WRITE = 2'b10;  // low six bits carry the address

  // rx event codes
  localparam rx_event_t RX_EVENT_ACTIVE = 2'b01;
  localparam rx_event_t RX_EVENT_ERROR  = 2'b11;  // error implies active

  // encoder sequencing
  typedef enum logic [2:0] {
    idle,      // waiting for a write or a packet
    tx_pid,    // transmit cmd with pid on the bus
    tx_data,   // packet bytes, one per nxt
    tx_stop,   // stp after last byte
    reg_cmd,   // reg write cmd with address
    reg_data,  // register value
    reg_stop   // stp closes the write
  } enc_state_t;

endpackage

// File: design/ulpi_reset_sync.sv
`timescale 1ns/1ps
module ulpi_reset_sync (
  input  logic clock,
  input  logic areset_n,
  output logic reset_no
);

  logic [1:0] sync_q;  // release shifts through here

  // asserts at once, releases two phy clocks later
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign reset_no = sync_q[1];  // resets the rest of the link

endmodule

// File: filelist.f
design/ulpi_pkg.sv
design/ulpi_reset_sync.sv
design/ulpi_line_state.sv
design/ulpi_decoder.sv
design/ulpi_encoder.sv
design/ulpi_axis.sv
bench/ulpi_axis_tb.sv
